/* sources.f */
common/noc_flit_pkg.sv
common/noc_cfg_pkg.sv
common/noc_flit_if.sv
hdl/noc_demux.sv
hdl/noc_buffer.sv
hdl/noc_mux.sv
hdl/noc_class_queue.sv
testbench/tb_noc_class_queue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides pass or fail

cd "$(dirname "$0")" || exit 1

TOP=tb_noc_class_queue
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module "$TOP" --Mdir "$OBJ_DIR" -o "$TOP" -f sources.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   echo "FAIL"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi
echo "PASS"
exit 0

/* testbench/tb_noc_class_queue.sv */
module tb_noc_class_queue;

   localparam int FLIT_W     = noc_flit_pkg::flit_width_default;
   localparam int TOTAL_PKTS = 92;                   // 40 + 12 + 40 packets
   localparam int WATCHDOG   = TOTAL_PKTS * 4 * 50;  // in cycles with up to 4 flits per packet

   logic              clk      = 1'b0;
   logic              rst      = 1'b1;
   logic [FLIT_W-1:0] in_flit  = '0;
   logic              in_last  = 1'b0;
   logic              in_valid = 1'b0;
   logic              in_ready;
   logic [FLIT_W-1:0] out_flit;
   logic              out_last;
   logic              out_valid;
   logic              out_ready = 1'b0;

   // reference queues of {last, flit} per channel in arrival order
   logic [FLIT_W:0] ref_q0 [$];
   logic [FLIT_W:0] ref_q1 [$];
   logic [FLIT_W:0] head [2];   // queue heads as of the previous edge
   int              qsize [2];

   logic        in_first, in_fire, seen_input;
   logic        out_first, held, hold_last, rr_due;
   logic        hold_low  = 1'b0;  // long output stall phase
   logic        saw_block = 1'b0;
   logic [FLIT_W-1:0] hold_flit;
   logic [15:0] out_pkt_num;
   int          in_pkt_chan, out_pkt_chan, last_served;
   int          sent_pkts, recv_pkts;
   int          next_num = 0;
   int          out_chan;
   logic [FLIT_W:0] exp_word;
   logic        exp_avail;
   logic        out_fire;

   noc_class_queue #(
      .FLIT_WIDTH   (FLIT_W),
      .CHANNELS     (noc_cfg_pkg::channels_default),
      .MAPPING      (noc_cfg_pkg::mapping_default),
      .BUFFER_DEPTH (noc_cfg_pkg::buffer_depth_default)
   ) u_dut (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_last   (in_last),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   always #4 clk = ~clk;  // period 8

   // channel from the one-hot class byte of the mapping table
   // zero entry falls back to channel 0
   function automatic int chan_of(input logic [FLIT_W-1:0] flit);
      logic [2:0] cls;
      logic [7:0] entry;
      int         chan;
      cls   = flit[noc_flit_pkg::class_msb:noc_flit_pkg::class_lsb];
      entry = noc_cfg_pkg::mapping_default[8 * int'(cls) +: 8];
      chan  = 0;
      for (int c = 0; c < noc_cfg_pkg::channels_default; c++) begin
         if (entry[c]) begin
            chan = c;
         end
      end
      return chan;
   endfunction

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_failure(input string msg);
      $display("%s at time %0t", msg, $time);
      abort_run();
   endtask

   task automatic flag_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run();
   endtask

   // packet number in bits 23:8 and flit index in bits 7:0
   // class field only meaningful in flit 0
   task automatic send_packet();
      int                       len;
      noc_flit_pkg::pkt_class_e cls;
      logic [31:0]              word;
      len = $urandom_range(4, 1);
      cls = noc_flit_pkg::pkt_class_e'($urandom_range(7, 0));
      for (int f = 0; f < len; f++) begin
         word       = $urandom();  // later flits carry junk in the class bits
         word[23:8] = next_num[15:0];
         word[7:0]  = 8'(f);
         if (f == 0) begin
            word[noc_flit_pkg::class_msb:noc_flit_pkg::class_lsb] = cls;
         end
         in_flit  = word;
         in_last  = (f == len - 1);
         in_valid = 1'b1;
         do @(negedge clk); while (!in_fire);  // held until accepted
      end
      in_valid = 1'b0;
      next_num++;
      if ($urandom_range(3, 0) == 0) begin
         @(negedge clk);  // occasional idle gap
      end
   endtask

   always @(negedge clk) begin
      out_ready = !hold_low && ($urandom_range(3, 0) != 0);  // ready about 3 of 4
   end

   assign out_fire  = out_valid && out_ready;
   assign out_chan  = out_first ? chan_of(out_flit) : out_pkt_chan;
   assign exp_word  = (out_chan == 0) ? head[0] : head[1];
   assign exp_avail = qsize[out_chan] > 0;

   always @(posedge clk) begin : ref_model
      int ch;
      if (rst) begin
         in_first   <= 1'b1;
         out_first  <= 1'b1;
         in_fire    <= 1'b0;
         seen_input <= 1'b0;
         held       <= 1'b0;
         rr_due     <= 1'b0;
         sent_pkts  <= 0;
         recv_pkts  <= 0;
      end else begin
         in_fire   <= in_valid && in_ready;
         held      <= out_valid && !out_ready;  // stalled flit must hold next cycle
         hold_flit <= out_flit;
         hold_last <= out_last;
         if (hold_low && in_valid && !in_ready) begin
            saw_block <= 1'b1;
         end
         // pop before push since a flit never leaves on the edge it arrives
         if (out_fire) begin
            if (out_chan == 0 && ref_q0.size() > 0) begin
               void'(ref_q0.pop_front());
            end else if (out_chan == 1 && ref_q1.size() > 0) begin
               void'(ref_q1.pop_front());
            end
            out_first    <= out_last;
            out_pkt_chan <= out_chan;
            if (out_first) begin
               out_pkt_num <= out_flit[23:8];
            end
            rr_due <= 1'b0;
            if (out_last) begin
               recv_pkts   <= recv_pkts + 1;
               last_served <= out_chan;
               rr_due      <= qsize[1 - out_chan] > 0;  // other channel waiting
            end
         end
         if (in_valid && in_ready) begin
            ch = in_first ? chan_of(in_flit) : in_pkt_chan;  // body follows the head
            if (ch == 0) begin
               ref_q0.push_back({in_last, in_flit});
            end else begin
               ref_q1.push_back({in_last, in_flit});
            end
            seen_input  <= 1'b1;
            in_first    <= in_last;
            in_pkt_chan <= ch;
            if (in_last) begin
               sent_pkts <= sent_pkts + 1;
            end
         end
      end
      qsize[0] <= ref_q0.size();
      qsize[1] <= ref_q1.size();
      head[0]  <= (ref_q0.size() > 0) ? ref_q0[0] : '0;
      head[1]  <= (ref_q1.size() > 0) ? ref_q1[0] : '0;
   end

   a_idle: assert property (@(posedge clk) disable iff (rst) !seen_input |-> !out_valid)
      else flag_mismatch("out_valid", 32'($sampled(out_valid)), 32'd0);
   a_avail: assert property (@(posedge clk) disable iff (rst) out_fire |-> exp_avail)
      else report_failure("output flit while the reference queue of its channel is empty");
   a_flit: assert property (@(posedge clk) disable iff (rst)
                            out_fire && exp_avail |-> out_flit == exp_word[FLIT_W-1:0])
      else flag_mismatch("out_flit", $sampled(out_flit), $sampled(exp_word[FLIT_W-1:0]));
   a_last: assert property (@(posedge clk) disable iff (rst)
                            out_fire && exp_avail |-> out_last == exp_word[FLIT_W])
      else flag_mismatch("out_last", 32'($sampled(out_last)),
                         32'($sampled(exp_word[FLIT_W])));
   a_pkt: assert property (@(posedge clk) disable iff (rst)
                           out_fire && !out_first |-> out_flit[23:8] == out_pkt_num)
      else flag_mismatch("out_flit packet number", 32'($sampled(out_flit[23:8])),
                         32'($sampled(out_pkt_num)));
   a_hold_valid: assert property (@(posedge clk) disable iff (rst) held |-> out_valid)
      else flag_mismatch("out_valid", 32'($sampled(out_valid)), 32'd1);
   a_hold_flit: assert property (@(posedge clk) disable iff (rst) held |-> out_flit == hold_flit)
      else flag_mismatch("out_flit", $sampled(out_flit), $sampled(hold_flit));
   a_hold_last: assert property (@(posedge clk) disable iff (rst) held |-> out_last == hold_last)
      else flag_mismatch("out_last", 32'($sampled(out_last)), 32'($sampled(hold_last)));
   a_rr: assert property (@(posedge clk) disable iff (rst)
                          out_fire && out_first && rr_due |-> out_chan != last_served)
      else report_failure($sformatf("channel %0d served twice while channel %0d was backlogged",
                                    $sampled(last_served), 1 - $sampled(last_served)));

   initial begin
      void'($urandom(32'h0087_99e0));  // single seed for the run
      repeat (5) @(negedge clk);
      rst = 1'b0;
      repeat (40) send_packet();
      hold_low = 1'b1;  // output stalled so both buffers fill up
      fork
         repeat (12) send_packet();
         begin
            repeat (60) @(negedge clk);
            a_block: assert (saw_block)
               else report_failure("in_ready never dropped during the output stall");
            hold_low = 1'b0;
         end
      join
      repeat (40) send_packet();
      for (int i = 0; i < 400 && recv_pkts != sent_pkts; i++) begin
         @(negedge clk);  // drain
      end
      a_count: assert (recv_pkts == TOTAL_PKTS && sent_pkts == TOTAL_PKTS)
         else report_failure($sformatf("%0d packets sent, %0d received", sent_pkts, recv_pkts));
      a_empty: assert (ref_q0.size() == 0 && ref_q1.size() == 0)
         else report_failure("flits left in the reference queues after drain");
      $display("Simulation completed successfully");
      $finish;
   end

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      report_failure($sformatf("watchdog timeout after %0d cycles", WATCHDOG));
   end

endmodule

/* hdl/noc_class_queue.sv */
module noc_class_queue #(
   parameter int          FLIT_WIDTH   = noc_flit_pkg::flit_width_default,
   parameter int          CHANNELS     = noc_cfg_pkg::channels_default,
   parameter logic [63:0] MAPPING      = noc_cfg_pkg::mapping_default,
   parameter int          BUFFER_DEPTH = noc_cfg_pkg::buffer_depth_default
) (
   input  logic                  clk,
   input  logic                  rst,

   // packet stream in
   input  logic [FLIT_WIDTH-1:0] in_flit,
   input  logic                  in_last,
   input  logic                  in_valid,
   output logic                  in_ready,

   // merged stream out
   output logic [FLIT_WIDTH-1:0] out_flit,
   output logic                  out_last,
   output logic                  out_valid,
   input  logic                  out_ready
);

   noc_flit_if #(.FLIT_WIDTH(FLIT_WIDTH)) chan_in  [CHANNELS] ();  // demux -> buffers
   noc_flit_if #(.FLIT_WIDTH(FLIT_WIDTH)) chan_out [CHANNELS] ();  // buffers -> mux

   noc_demux #(
      .FLIT_WIDTH (FLIT_WIDTH),
      .CHANNELS   (CHANNELS),
      .MAPPING    (MAPPING)
   ) u_demux (
      .clk      (clk),
      .rst      (rst),
      .in_flit  (in_flit),
      .in_last  (in_last),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .chan_out (chan_in)
   );

   // one FIFO per channel, a stalled class only fills its own
   genvar i;
   generate
      for (i = 0; i < CHANNELS; i++) begin : g_buf
         noc_buffer #(
            .FLIT_WIDTH   (FLIT_WIDTH),
            .BUFFER_DEPTH (BUFFER_DEPTH)
         ) u_buffer (
            .clk      (clk),
            .rst      (rst),
            .in_port  (chan_in[i]),
            .out_port (chan_out[i])
         );
      end
   endgenerate

   noc_mux #(
      .FLIT_WIDTH (FLIT_WIDTH),
      .CHANNELS   (CHANNELS)
   ) u_mux (
      .clk       (clk),
      .rst       (rst),
      .chan_in   (chan_out),
      .out_flit  (out_flit),
      .out_last  (out_last),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

/* hdl/noc_mux.sv */
module noc_mux #(
   parameter int FLIT_WIDTH = noc_flit_pkg::flit_width_default,
   parameter int CHANNELS   = noc_cfg_pkg::channels_default
) (
   input  logic                  clk,
   input  logic                  rst,

   noc_flit_if.sink              chan_in [CHANNELS],

   output logic [FLIT_WIDTH-1:0] out_flit,
   output logic                  out_last,
   output logic                  out_valid,
   input  logic                  out_ready
);

   localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

   noc_cfg_pkg::merge_state_e state;

   logic [CH_W-1:0]       rr_ptr;     // channel with top priority
   logic [CH_W-1:0]       sel;        // owner while locked
   logic [CH_W-1:0]       grant;      // round-robin winner while idle
   logic [CH_W-1:0]       cur;        // channel on the output this cycle
   logic [CH_W-1:0]       next_ptr;
   logic                  found;
   logic [CHANNELS-1:0]   valid_vec;
   logic [CHANNELS-1:0]   last_vec;
   logic [FLIT_WIDTH-1:0] flit_arr [CHANNELS];

   genvar i;
   generate
      for (i = 0; i < CHANNELS; i++) begin : g_chan
         assign valid_vec[i]     = chan_in[i].valid;
         assign last_vec[i]      = chan_in[i].last;
         assign flit_arr[i]      = chan_in[i].flit;
         assign chan_in[i].ready = out_ready & (cur == CH_W'(i));  // only the owner drains
      end
   endgenerate

   // first valid channel at or after rr_ptr
   always_comb begin
      grant = rr_ptr;
      found = 1'b0;
      for (int k = 0; k < CHANNELS; k++) begin
         if (!found && valid_vec[(int'(rr_ptr) + k) % CHANNELS]) begin
            grant = CH_W'((int'(rr_ptr) + k) % CHANNELS);
            found = 1'b1;
         end
      end
   end

   assign cur = (state == noc_cfg_pkg::merge_locked) ? sel : grant;

   // grant falls back to rr_ptr when nothing is valid, so out_valid stays low
   assign out_valid = valid_vec[cur];
   assign out_flit  = flit_arr[cur];
   assign out_last  = last_vec[cur];

   assign next_ptr = (cur == CH_W'(CHANNELS - 1)) ? '0 : cur + 1'b1;

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= noc_cfg_pkg::merge_idle;
         rr_ptr <= '0;
         sel    <= '0;
      end else if (out_valid && out_ready && out_last) begin
         state  <= noc_cfg_pkg::merge_idle;  // packet done
         rr_ptr <= next_ptr;                 // served channel drops to lowest priority
      end else if (state == noc_cfg_pkg::merge_idle && out_valid) begin
         // lock on first valid flit, keeps output stable under stall
         state <= noc_cfg_pkg::merge_locked;
         sel   <= grant;
      end
   end

endmodule

/* hdl/noc_buffer.sv */
module noc_buffer #(
   parameter int FLIT_WIDTH   = noc_flit_pkg::flit_width_default,
   parameter int BUFFER_DEPTH = noc_cfg_pkg::buffer_depth_default
) (
   input  logic     clk,
   input  logic     rst,
   noc_flit_if.sink   in_port,
   noc_flit_if.source out_port
);

   localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);

   logic [FLIT_WIDTH:0] mem [BUFFER_DEPTH];  // {last, flit}

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;   // flits stored
   logic             push;
   logic             pop;

   // full check uses the registered count, so a pop frees space a cycle later
   assign in_port.ready = (count != CNT_W'(BUFFER_DEPTH));
   assign push          = in_port.valid & in_port.ready;

   // head of the FIFO straight from storage
   assign out_port.valid = (count != '0);
   assign out_port.flit  = mem[rd_ptr][FLIT_WIDTH-1:0];
   assign out_port.last  = mem[rd_ptr][FLIT_WIDTH];
   assign pop            = out_port.valid & out_port.ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {in_port.last, in_port.flit};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            // wrap by hand, depth need not be a power of two
            wr_ptr <= (wr_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

endmodule

/* hdl/noc_demux.sv */
module noc_demux #(
   parameter int          FLIT_WIDTH = noc_flit_pkg::flit_width_default,
   parameter int          CHANNELS   = noc_cfg_pkg::channels_default,
   parameter logic [63:0] MAPPING    = noc_cfg_pkg::mapping_default
) (
   input  logic                  clk,
   input  logic                  rst,

   input  logic [FLIT_WIDTH-1:0] in_flit,
   input  logic                  in_last,
   input  logic                  in_valid,
   output logic                  in_ready,

   noc_flit_if.source            chan_out [CHANNELS]
);

   noc_flit_pkg::pkt_class_e pkt_class;  // class of the flit at the input

   logic [CHANNELS-1:0] active;      // channel held for the current packet, 0 when free
   logic [CHANNELS-1:0] select;      // channel looked up from the class field
   logic [CHANNELS-1:0] route;       // channel this flit goes to
   logic [CHANNELS-1:0] chan_ready;

   assign pkt_class = noc_flit_pkg::pkt_class_e'(
                         in_flit[noc_flit_pkg::class_msb:noc_flit_pkg::class_lsb]);

   // mapping lookup
   always_comb begin
      select = MAPPING[8 * int'(pkt_class) +: CHANNELS];
      if (select == '0) begin
         select = CHANNELS'(1);  // unmapped class goes to channel 0
      end
   end

   // only the first flit of a packet decides, later flits follow it
   assign route = (active == '0) ? select : active;

   genvar i;
   generate
      for (i = 0; i < CHANNELS; i++) begin : g_chan
         assign chan_out[i].flit  = in_flit;   // broadcast data
         assign chan_out[i].last  = in_last;
         assign chan_out[i].valid = in_valid & route[i];  // valid only on the routed channel
         assign chan_ready[i]     = chan_out[i].ready;
      end
   endgenerate

   // stall when the routed buffer is full
   assign in_ready = |(route & chan_ready);

   // latch the route on an accepted non-last flit, free it on the last one
   // single-flit packet never latches
   always_ff @(posedge clk) begin
      if (rst) begin
         active <= '0;
      end else if (in_valid && in_ready) begin
         if (in_last) begin
            active <= '0;
         end else begin
            active <= route;
         end
      end
   end

endmodule

/* common/noc_flit_if.sv */
interface noc_flit_if #(
   parameter int FLIT_WIDTH = noc_flit_pkg::flit_width_default
) ();

   logic [FLIT_WIDTH-1:0] flit;   // payload, class in first flit
   logic                  last;   // marks final flit of a packet
   logic                  valid;
   logic                  ready;

   // flit moves on valid & ready
   // source keeps flit and last stable while stalled

   modport source (
      output flit,
      output last,
      output valid,
      input  ready
   );

   modport sink (
      input  flit,
      input  last,
      input  valid,
      output ready
   );

endinterface

/* common/noc_cfg_pkg.sv */
package noc_cfg_pkg;

   localparam int channels_default     = 2;  // flit buffers behind the demux
   localparam int buffer_depth_default = 4;  // flits per channel buffer

   // one byte per class, byte n for class n
   // low CHANNELS bits of each byte are a one-hot channel mask
   // dma -> ch1, msg -> ch0, sync -> ch1, rest zero (falls back to ch0)
   localparam logic [63:0] mapping_default = 64'h0000_0000_0002_0102;

   // output merge FSM
   typedef enum logic {
      merge_idle,    // no channel owns the output
      merge_locked   // one channel holds the output until its last flit
   } merge_state_e;

endpackage

/* common/noc_flit_pkg.sv */
package noc_flit_pkg;

   // default flit width, data plus header bits
   localparam int flit_width_default = 32;

   // class field sits in the first flit of a packet
   localparam int class_msb = 26;
   localparam int class_lsb = 24;

   // traffic classes, encoded as the 3-bit class field
   typedef enum logic [2:0] {
      class_dma   = 3'd0,  // bulk transfers
      class_msg   = 3'd1,  // message passing
      class_sync  = 3'd2,  // barriers, locks
      class_debug = 3'd3,  // debug traffic
      class_rsv4  = 3'd4,
      class_rsv5  = 3'd5,
      class_rsv6  = 3'd6,
      class_rsv7  = 3'd7   // spare encodings, map to channel 0 unless configured
   } pkt_class_e;

endpackage
